// ==== rtl/tank_game_config.svh ====
// tank game constants for the screen, tanks, bullets, walls and fire rate
`ifndef TANK_GAME_CONFIG_SVH
`define TANK_GAME_CONFIG_SVH

// screen in pixels
`define SCREEN_W 640
`define SCREEN_H 480

// object sizes
`define TANK_SIZE 32
`define BULLET_RADIUS 4     // margin of a bullet point against walls
`define WALL_SIZE 32

// counts
`define NUM_TANKS 2
`define NUM_SLOTS 4         // bullet slots per tank
`define NUM_WALLS 4

`define FIRE_PERIOD 16      // power of two

// reset positions, upper left corner
`define TANK0_X0 200
`define TANK0_Y0 200
`define TANK1_X0 400
`define TANK1_Y0 400

`endif

// ==== rtl/tank_game_pkg.sv ====
// tank game types: coordinates, keys, turret angle, fire counter and directions
package tank_game_pkg;

	typedef logic [9:0] coord_t;            // screen x or y
	typedef logic [7:0] key_t;
	typedef logic [7:0] turret_angle_t;     // coarse direction in [6:4]
	typedef logic [7:0] frame_cnt_t;

	// counter clockwise from up
	typedef enum logic [2:0] {
		UP         = 3'd0,
		UP_LEFT    = 3'd1,
		LEFT       = 3'd2,
		DOWN_LEFT  = 3'd3,
		DOWN       = 3'd4,
		DOWN_RIGHT = 3'd5,
		RIGHT      = 3'd6,
		UP_RIGHT   = 3'd7
	} dir_e;

	// base keys
	localparam key_t KEY_LEFT  = 8'd1;
	localparam key_t KEY_DOWN  = 8'd2;
	localparam key_t KEY_UP    = 8'd3;
	localparam key_t KEY_RIGHT = 8'd4;

	// turret keys
	localparam key_t KEY_ROT_CCW = 8'd1;   // angle +1
	localparam key_t KEY_ROT_CW  = 8'd2;   // angle -1
	localparam key_t KEY_FIRE    = 8'd3;

endpackage

// ==== rtl/wall_overlap.sv ====
// wall overlap test of one box against every wall in the list
`timescale 1ns/1ps
`include "tank_game_config.svh"

module wall_overlap
	import tank_game_pkg::*;
#(
	parameter int BOX  = `TANK_SIZE,   // side of the tested box, 0 for a point
	parameter int GROW = 0             // margin added around each wall
) (
	input  coord_t                  x,
	input  coord_t                  y,
	input  coord_t [`NUM_WALLS-1:0] wall_x,
	input  coord_t [`NUM_WALLS-1:0] wall_y,
	output logic                    overlap
);

	// two spare bits so grown edges near the screen border do not wrap
	typedef logic [11:0] wide_t;

	wide_t box_r;
	wide_t box_b;
	wide_t wall_r;
	wide_t wall_b;

	always_comb begin
		// the margin is folded into the box side on the low edge
		box_r = wide_t'(x) + wide_t'(BOX + GROW);
		box_b = wide_t'(y) + wide_t'(BOX + GROW);
		overlap = 1'b0;
		for (int w = 0; w < `NUM_WALLS; w++) begin
			wall_r = wide_t'(wall_x[w]) + wide_t'(`WALL_SIZE + GROW);
			wall_b = wide_t'(wall_y[w]) + wide_t'(`WALL_SIZE + GROW);
			if (box_r > wide_t'(wall_x[w]) && wide_t'(x) < wall_r &&
			    box_b > wide_t'(wall_y[w]) && wide_t'(y) < wall_b)
				overlap = 1'b1;
		end
	end

endmodule

// ==== rtl/tank_mover.sv ====
// tank mover: position, base heading, turret angle and fire latch of one tank
`timescale 1ns/1ps
`include "tank_game_config.svh"

module tank_mover
	import tank_game_pkg::*;
#(
	parameter coord_t X0 = coord_t'(`TANK0_X0),
	parameter coord_t Y0 = coord_t'(`TANK0_Y0)
) (
	input  logic                    Reset,
	input  logic                    frame_clk,
	input  key_t                    base_key,
	input  key_t                    turret_key,
	input  coord_t [`NUM_WALLS-1:0] wall_x,
	input  coord_t [`NUM_WALLS-1:0] wall_y,
	output coord_t                  tank_x,
	output coord_t                  tank_y,
	output dir_e                    base_dir,
	output dir_e                    turret_dir,
	output logic                    fire_strobe
);

	localparam coord_t     X_MAX     = coord_t'(`SCREEN_W - `TANK_SIZE);
	localparam coord_t     Y_MAX     = coord_t'(`SCREEN_H - `TANK_SIZE);
	localparam frame_cnt_t FIRE_MASK = frame_cnt_t'(`FIRE_PERIOD - 1);

	coord_t        cand_x;
	coord_t        cand_y;
	dir_e          next_dir;
	logic          blocked;     // candidate box touches a wall
	turret_angle_t turret_angle;
	logic          fire_latch;
	frame_cnt_t    fire_cnt;

	// ----------------------------------------------------------
	// base movement
	// ----------------------------------------------------------
	always_comb begin
		cand_x = tank_x;
		cand_y = tank_y;
		next_dir = base_dir;
		case (base_key)
			KEY_LEFT: begin
				if (tank_x != '0)
					cand_x = tank_x - 1'b1;
				next_dir = LEFT;
			end
			KEY_DOWN: begin
				if (tank_y < Y_MAX)
					cand_y = tank_y + 1'b1;
				next_dir = DOWN;
			end
			KEY_UP: begin
				if (tank_y != '0)
					cand_y = tank_y - 1'b1;
				next_dir = UP;
			end
			KEY_RIGHT: begin
				if (tank_x < X_MAX)
					cand_x = tank_x + 1'b1;
				next_dir = RIGHT;
			end
			default: ;   // idle codes
		endcase
	end

	wall_overlap #(.BOX(`TANK_SIZE), .GROW(0)) wall_i (
		.x      (cand_x),
		.y      (cand_y),
		.wall_x (wall_x),
		.wall_y (wall_y),
		.overlap(blocked)
	);

	// ----------------------------------------------------------
	// turret and fire
	// ----------------------------------------------------------
	assign turret_dir  = dir_e'(turret_angle[6:4]);
	assign fire_strobe = fire_latch && ((fire_cnt & FIRE_MASK) == '0);

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			tank_x <= X0;
			tank_y <= Y0;
			base_dir <= UP;
			turret_angle <= '0;
			fire_latch <= 1'b0;
			fire_cnt <= '0;
		end else begin
			if (!blocked) begin
				tank_x <= cand_x;
				tank_y <= cand_y;
			end
			base_dir <= next_dir;   // heading turns even when blocked
			case (turret_key)
				KEY_ROT_CCW: turret_angle <= turret_angle + 1'b1;
				KEY_ROT_CW:  turret_angle <= turret_angle - 1'b1;
				default: ;
			endcase
			if (fire_strobe)
				fire_latch <= 1'b0;   // request consumed, slot or not
			else if (turret_key == KEY_FIRE)
				fire_latch <= 1'b1;
			fire_cnt <= fire_cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/bullet_step.sv ====
// bullet step: next position, survival and tank hits of one bullet for a frame
`timescale 1ns/1ps
`include "tank_game_config.svh"

module bullet_step
	import tank_game_pkg::*;
(
	input  logic                    live,
	input  dir_e                    dir,
	input  coord_t                  x,
	input  coord_t                  y,
	input  coord_t [`NUM_TANKS-1:0] tanks_x,
	input  coord_t [`NUM_TANKS-1:0] tanks_y,
	input  coord_t [`NUM_WALLS-1:0] wall_x,
	input  coord_t [`NUM_WALLS-1:0] wall_y,
	output logic                    next_live,
	output coord_t                  next_x,
	output coord_t                  next_y,
	output logic [`NUM_TANKS-1:0]   tank_hit
);

	logic   go_left;
	logic   go_right;
	logic   go_up;
	logic   go_down;
	coord_t rel_x;       // offset from a tank corner
	coord_t rel_y;
	logic   on_screen;
	logic   wall_hit;

	// split the heading into its horizontal and vertical parts
	assign go_left  = dir inside {UP_LEFT, LEFT, DOWN_LEFT};
	assign go_right = dir inside {DOWN_RIGHT, RIGHT, UP_RIGHT};
	assign go_up    = dir inside {UP_LEFT, UP, UP_RIGHT};
	assign go_down  = dir inside {DOWN_LEFT, DOWN, DOWN_RIGHT};

	// stepping left or up from 0 wraps to 1023, past either screen edge
	always_comb begin
		next_x = x;
		next_y = y;
		if (go_left)
			next_x = x - 1'b1;
		else if (go_right)
			next_x = x + 1'b1;
		if (go_up)
			next_y = y - 1'b1;
		else if (go_down)
			next_y = y + 1'b1;
	end

	// a point is inside a tank when both wrapped offsets are small
	always_comb begin
		tank_hit = '0;
		for (int t = 0; t < `NUM_TANKS; t++) begin
			rel_x = x - tanks_x[t];
			rel_y = y - tanks_y[t];
			tank_hit[t] = live && (rel_x < coord_t'(`TANK_SIZE)) &&
			              (rel_y < coord_t'(`TANK_SIZE));
		end
	end

	assign on_screen = (next_x < coord_t'(`SCREEN_W)) && (next_y < coord_t'(`SCREEN_H));

	wall_overlap #(.BOX(0), .GROW(`BULLET_RADIUS)) wall_i (
		.x      (next_x),
		.y      (next_y),
		.wall_x (wall_x),
		.wall_y (wall_y),
		.overlap(wall_hit)
	);

	assign next_live = live && !(|tank_hit) && on_screen && !wall_hit;

endmodule

// ==== rtl/bullet_bank.sv ====
// bullet bank: bullet slots of one tank with free-slot choice and spawn point
`timescale 1ns/1ps
`include "tank_game_config.svh"

module bullet_bank
	import tank_game_pkg::*;
(
	input  logic                    Reset,
	input  logic                    frame_clk,
	input  logic                    fire_strobe,
	input  coord_t                  own_x,
	input  coord_t                  own_y,
	input  dir_e                    aim,
	input  coord_t [`NUM_TANKS-1:0] tanks_x,
	input  coord_t [`NUM_TANKS-1:0] tanks_y,
	input  coord_t [`NUM_WALLS-1:0] wall_x,
	input  coord_t [`NUM_WALLS-1:0] wall_y,
	output logic [`NUM_SLOTS-1:0]   bullet_valid,
	output coord_t [`NUM_SLOTS-1:0] bullet_x,
	output coord_t [`NUM_SLOTS-1:0] bullet_y,
	output logic [`NUM_TANKS-1:0]   hit
);

	dir_e [`NUM_SLOTS-1:0]                  slot_dir;
	logic [`NUM_SLOTS-1:0]                  step_live;
	coord_t [`NUM_SLOTS-1:0]                step_x;
	coord_t [`NUM_SLOTS-1:0]                step_y;
	logic [`NUM_SLOTS-1:0][`NUM_TANKS-1:0] slot_hit;
	logic [`NUM_SLOTS-1:0]                  load;      // one-hot spawn target
	logic                                   taken;
	logic [`NUM_TANKS-1:0]                  hit_any;
	coord_t                                 spawn_x;
	coord_t                                 spawn_y;

	for (genvar s = 0; s < `NUM_SLOTS; s++) begin : g_slot
		bullet_step step_i (
			.live     (bullet_valid[s]),
			.dir      (slot_dir[s]),
			.x        (bullet_x[s]),
			.y        (bullet_y[s]),
			.tanks_x  (tanks_x),
			.tanks_y  (tanks_y),
			.wall_x   (wall_x),
			.wall_y   (wall_y),
			.next_live(step_live[s]),
			.next_x   (step_x[s]),
			.next_y   (step_y[s]),
			.tank_hit (slot_hit[s])
		);
	end

	// ----------------------------------------------------------
	// lowest free slot and hit merge
	// ----------------------------------------------------------
	always_comb begin
		load = '0;
		taken = 1'b0;
		hit_any = '0;
		for (int s = 0; s < `NUM_SLOTS; s++) begin
			if (!bullet_valid[s] && !taken) begin
				load[s] = fire_strobe;
				taken = 1'b1;
			end
			hit_any = hit_any | slot_hit[s];
		end
	end

	// spawn just outside the tank on the aimed side
	always_comb begin
		case (aim)
			RIGHT, DOWN_RIGHT, UP_RIGHT: spawn_x = own_x + coord_t'(`TANK_SIZE);
			LEFT, DOWN_LEFT, UP_LEFT:    spawn_x = own_x - 1'b1;
			default:                     spawn_x = own_x + coord_t'(`TANK_SIZE / 2);
		endcase
		case (aim)
			UP, UP_LEFT, UP_RIGHT:       spawn_y = own_y - 1'b1;
			DOWN, DOWN_LEFT, DOWN_RIGHT: spawn_y = own_y + coord_t'(`TANK_SIZE);
			default:                     spawn_y = own_y + coord_t'(`TANK_SIZE / 2);
		endcase
	end

	// ----------------------------------------------------------
	// slot registers
	// ----------------------------------------------------------
	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			bullet_valid <= '0;
			hit <= '0;
		end else begin
			bullet_valid <= load | step_live;   // a free slot has no live step
			hit <= hit_any;
		end
	end

	always_ff @(posedge Reset) begin
		for (int s = 0; s < `NUM_SLOTS; s++) begin
			if (load[s]) begin
				slot_dir[s] <= aim;
				bullet_x[s] <= spawn_x;
				bullet_y[s] <= spawn_y;
			end else if (bullet_valid[s]) begin
				bullet_x[s] <= step_x[s];
				bullet_y[s] <= step_y[s];
			end
		end
	end

endmodule

// ==== rtl/tank_game_top.sv ====
// tank game top: two tanks and their bullet banks, advanced once per frame
`timescale 1ns/1ps
`include "tank_game_config.svh"

module tank_game_top
	import tank_game_pkg::*;
(
	input  logic                                    Reset,       // frame clock
	input  logic                                    frame_clk,   // async reset
	input  key_t [`NUM_TANKS-1:0]                   base_key,
	input  key_t [`NUM_TANKS-1:0]                   turret_key,
	input  coord_t [`NUM_WALLS-1:0]                 wall_x,
	input  coord_t [`NUM_WALLS-1:0]                 wall_y,
	output coord_t [`NUM_TANKS-1:0]                 tank_x,
	output coord_t [`NUM_TANKS-1:0]                 tank_y,
	output dir_e [`NUM_TANKS-1:0]                   base_dir,
	output dir_e [`NUM_TANKS-1:0]                   turret_dir,
	output logic [`NUM_TANKS-1:0][`NUM_SLOTS-1:0]   bullet_valid,
	output coord_t [`NUM_TANKS-1:0][`NUM_SLOTS-1:0] bullet_x,
	output coord_t [`NUM_TANKS-1:0][`NUM_SLOTS-1:0] bullet_y,
	output logic [`NUM_TANKS-1:0]                   hit
);

	logic [`NUM_TANKS-1:0]                  fire_strobe;
	logic [`NUM_TANKS-1:0][`NUM_TANKS-1:0] bank_hit;    // per bank, per target tank

	tank_mover #(.X0(coord_t'(`TANK0_X0)), .Y0(coord_t'(`TANK0_Y0))) mover0_i (
		.Reset(Reset), .frame_clk(frame_clk),
		.base_key(base_key[0]), .turret_key(turret_key[0]),
		.wall_x(wall_x), .wall_y(wall_y),
		.tank_x(tank_x[0]), .tank_y(tank_y[0]),
		.base_dir(base_dir[0]), .turret_dir(turret_dir[0]),
		.fire_strobe(fire_strobe[0])
	);

	tank_mover #(.X0(coord_t'(`TANK1_X0)), .Y0(coord_t'(`TANK1_Y0))) mover1_i (
		.Reset(Reset), .frame_clk(frame_clk),
		.base_key(base_key[1]), .turret_key(turret_key[1]),
		.wall_x(wall_x), .wall_y(wall_y),
		.tank_x(tank_x[1]), .tank_y(tank_y[1]),
		.base_dir(base_dir[1]), .turret_dir(turret_dir[1]),
		.fire_strobe(fire_strobe[1])
	);

	// each bank sees both tanks, so a bullet can also strike its owner
	bullet_bank bank0_i (
		.Reset(Reset), .frame_clk(frame_clk), .fire_strobe(fire_strobe[0]),
		.own_x(tank_x[0]), .own_y(tank_y[0]), .aim(turret_dir[0]),
		.tanks_x(tank_x), .tanks_y(tank_y), .wall_x(wall_x), .wall_y(wall_y),
		.bullet_valid(bullet_valid[0]), .bullet_x(bullet_x[0]), .bullet_y(bullet_y[0]),
		.hit(bank_hit[0])
	);

	bullet_bank bank1_i (
		.Reset(Reset), .frame_clk(frame_clk), .fire_strobe(fire_strobe[1]),
		.own_x(tank_x[1]), .own_y(tank_y[1]), .aim(turret_dir[1]),
		.tanks_x(tank_x), .tanks_y(tank_y), .wall_x(wall_x), .wall_y(wall_y),
		.bullet_valid(bullet_valid[1]), .bullet_x(bullet_x[1]), .bullet_y(bullet_y[1]),
		.hit(bank_hit[1])
	);

	assign hit = bank_hit[0] | bank_hit[1];

endmodule

// ==== testbench/tank_game_tb.sv ====
// tank game testbench: frame table with expected state, per-frame hit check, watchdog
`timescale 1ns/1ps
`include "tank_game_config.svh"

module tank_game_tb
	import tank_game_pkg::*;
();

	localparam key_t   IDLE   = 8'h00;    // replaced by a random idle code
	localparam coord_t PARK_X = 10'd608;  // spare walls sit in the top right corner
	localparam coord_t PARK_Y = 10'd0;

	typedef struct {
		int                                    frames;
		coord_t                                wx;
		coord_t                                wy;
		logic [`NUM_TANKS-1:0]                 hit;
		key_t [`NUM_TANKS-1:0]                 bk;
		key_t [`NUM_TANKS-1:0]                 tk;
		coord_t [`NUM_TANKS-1:0]               x;
		coord_t [`NUM_TANKS-1:0]               y;
		dir_e [`NUM_TANKS-1:0]                 bd;
		dir_e [`NUM_TANKS-1:0]                 td;
		logic [`NUM_TANKS-1:0][`NUM_SLOTS-1:0] v;
		coord_t [`NUM_TANKS-1:0]               bx;   // every live slot of the bank
		coord_t [`NUM_TANKS-1:0]               by;
	} row_t;

	logic                                    Reset;
	logic                                    frame_clk;
	key_t [`NUM_TANKS-1:0]                   base_key;
	key_t [`NUM_TANKS-1:0]                   turret_key;
	coord_t [`NUM_WALLS-1:0]                 wall_x;
	coord_t [`NUM_WALLS-1:0]                 wall_y;
	coord_t [`NUM_TANKS-1:0]                 tank_x;
	coord_t [`NUM_TANKS-1:0]                 tank_y;
	dir_e [`NUM_TANKS-1:0]                   base_dir;
	dir_e [`NUM_TANKS-1:0]                   turret_dir;
	logic [`NUM_TANKS-1:0][`NUM_SLOTS-1:0]   bullet_valid;
	coord_t [`NUM_TANKS-1:0][`NUM_SLOTS-1:0] bullet_x;
	coord_t [`NUM_TANKS-1:0][`NUM_SLOTS-1:0] bullet_y;
	logic [`NUM_TANKS-1:0]                   hit;

	row_t rows[$];
	int   total_frames = 0;
	int   coord_errs = 0;
	int   dir_errs = 0;
	int   bits_errs = 0;

	tank_game_top dut_i (
		.Reset(Reset), .frame_clk(frame_clk),
		.base_key(base_key), .turret_key(turret_key), .wall_x(wall_x), .wall_y(wall_y),
		.tank_x(tank_x), .tank_y(tank_y), .base_dir(base_dir), .turret_dir(turret_dir),
		.bullet_valid(bullet_valid), .bullet_x(bullet_x), .bullet_y(bullet_y), .hit(hit)
	);

	initial begin
		Reset = 1'b0;
		forever #2 Reset = ~Reset;
	end

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic check_coord(input coord_t got, input coord_t exp, input string what);
		if (got !== exp) begin
			coord_errs++;
			$display("error @ %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_dir(input dir_e got, input dir_e exp, input string what);
		if (got !== exp) begin
			dir_errs++;
			$display("error @ %0t ns: %s is %s, expected %s", $time, what, got.name(),
			         exp.name());
		end
	endtask

	task automatic check_bits(input logic [`NUM_SLOTS-1:0] got,
	                          input logic [`NUM_SLOTS-1:0] exp, input string what);
		if (got !== exp) begin
			bits_errs++;
			$display("error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// one bit per struck tank
	task automatic check_hit(input logic [`NUM_TANKS-1:0] got,
	                         input logic [`NUM_TANKS-1:0] exp, input string what);
		if (got !== exp) begin
			bits_errs++;
			$display("error @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_row(input row_t r, input int n);
		string tag;
		for (int t = 0; t < `NUM_TANKS; t++) begin
			tag = $sformatf("row %0d tank %0d", n, t);
			check_coord(tank_x[t], r.x[t], {tag, " x"});
			check_coord(tank_y[t], r.y[t], {tag, " y"});
			check_dir(base_dir[t], r.bd[t], {tag, " heading"});
			check_dir(turret_dir[t], r.td[t], {tag, " turret"});
			check_bits(bullet_valid[t], r.v[t], {tag, " bullet_valid"});
			for (int s = 0; s < `NUM_SLOTS; s++) begin
				if (r.v[t][s]) begin
					check_coord(bullet_x[t][s], r.bx[t], $sformatf("%s bullet %0d x", tag, s));
					check_coord(bullet_y[t][s], r.by[t], $sformatf("%s bullet %0d y", tag, s));
				end
			end
		end
	endtask

	// ----------------------------------------------------------
	// stimulus table
	// ----------------------------------------------------------
	task automatic add_row(input int n, input coord_t wx, input coord_t wy,
	                       input logic [`NUM_TANKS-1:0] hit_exp,
	                       input key_t bk0, input key_t tk0, input coord_t x0, input coord_t y0,
	                       input dir_e bd0, input dir_e td0, input logic [`NUM_SLOTS-1:0] v0,
	                       input coord_t bx0, input coord_t by0,
	                       input key_t bk1, input key_t tk1, input coord_t x1, input coord_t y1,
	                       input dir_e bd1, input dir_e td1, input logic [`NUM_SLOTS-1:0] v1,
	                       input coord_t bx1, input coord_t by1);
		row_t r;
		r.frames = n;
		r.wx = wx;
		r.wy = wy;
		r.hit = hit_exp;
		r.bk = {bk1, bk0};
		r.tk = {tk1, tk0};
		r.x = {x1, x0};
		r.y = {y1, y0};
		r.bd[0] = bd0;
		r.bd[1] = bd1;
		r.td[0] = td0;
		r.td[1] = td1;
		r.v = {v1, v0};
		r.bx = {bx1, bx0};
		r.by = {by1, by0};
		rows.push_back(r);
	endtask

	task automatic fill_table();
		add_row(  1, 608,   0, 2'b00, IDLE, IDLE, 200, 200, UP, UP, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, UP, UP, 4'h0, 0, 0);
		add_row(210, 608,   0, 2'b00, KEY_LEFT, IDLE, 0, 200, LEFT, UP, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, UP, UP, 4'h0, 0, 0);
		add_row(  4, 432, 400, 2'b00, IDLE, IDLE, 0, 200, LEFT, UP, 4'h0, 0, 0,
		        KEY_RIGHT, IDLE, 400, 400, RIGHT, UP, 4'h0, 0, 0);  // wall blocks tank 1
		add_row( 16, 432, 400, 2'b00, IDLE, KEY_ROT_CCW, 0, 200, LEFT, UP_LEFT, 4'h0, 0, 0,
		        IDLE, KEY_ROT_CCW, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		add_row( 16, 432, 400, 2'b00, IDLE, KEY_ROT_CCW, 0, 200, LEFT, LEFT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		add_row(  1, 432, 400, 2'b00, IDLE, KEY_FIRE, 0, 200, LEFT, LEFT, 4'h0, 0, 0,
		        IDLE, KEY_FIRE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		// both spawn at frame 257, counter wrapped back to 0
		add_row(  9, 432, 400, 2'b00, IDLE, IDLE, 0, 200, LEFT, LEFT, 4'h1, 1023, 216,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h1, 399, 399);
		add_row(  1, 432, 400, 2'b00, IDLE, IDLE, 0, 200, LEFT, LEFT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h1, 398, 398);
		add_row( 22, 340, 340, 2'b00, IDLE, IDLE, 0, 200, LEFT, LEFT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h1, 376, 376);
		add_row(  1, 340, 340, 2'b00, IDLE, IDLE, 0, 200, LEFT, LEFT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);  // next point in wall
		add_row( 64, 340, 340, 2'b00, KEY_DOWN, KEY_ROT_CW, 0, 264, DOWN, RIGHT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		add_row(136, 340, 340, 2'b00, KEY_DOWN, IDLE, 0, 400, DOWN, RIGHT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		add_row(  1, 340, 340, 2'b00, IDLE, KEY_FIRE, 0, 400, DOWN, RIGHT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		add_row( 15, 340, 340, 2'b00, IDLE, IDLE, 0, 400, DOWN, RIGHT, 4'h1, 32, 416,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		add_row(368, 340, 340, 2'b00, IDLE, IDLE, 0, 400, DOWN, RIGHT, 4'h1, 400, 416,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
		add_row(  1, 340, 340, 2'b10, IDLE, IDLE, 0, 400, DOWN, RIGHT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);  // tank 1 struck
		add_row(  1, 340, 340, 2'b00, IDLE, IDLE, 0, 400, DOWN, RIGHT, 4'h0, 0, 0,
		        IDLE, IDLE, 400, 400, RIGHT, UP_LEFT, 4'h0, 0, 0);
	endtask

	function automatic key_t pick_key(input key_t k);
		if (k == IDLE)
			return key_t'($urandom_range(255, 5));
		return k;
	endfunction

	task automatic apply_row(input row_t r);
		for (int t = 0; t < `NUM_TANKS; t++) begin
			base_key[t] = pick_key(r.bk[t]);
			turret_key[t] = pick_key(r.tk[t]);
		end
		wall_x[0] = r.wx;
		wall_y[0] = r.wy;
	endtask

	// ----------------------------------------------------------
	// main run and watchdog
	// ----------------------------------------------------------
	initial begin
		frame_clk = 1'b1;
		base_key = '0;
		turret_key = '0;
		wall_x = {`NUM_WALLS{PARK_X}};
		wall_y = {`NUM_WALLS{PARK_Y}};
		void'($urandom(80478));
		fill_table();
		foreach (rows[i])
			total_frames += rows[i].frames;
		repeat (16) @(negedge Reset);
		frame_clk = 1'b0;
		foreach (rows[i]) begin
			for (int f = 0; f < rows[i].frames; f++) begin
				apply_row(rows[i]);
				@(posedge Reset);
				@(negedge Reset);   // outputs settled half a period after the edge
				check_hit(hit, rows[i].hit, $sformatf("row %0d hit", i));
			end
			check_row(rows[i], i);
		end
		$display("checks done: %0d coord errors, %0d dir errors, %0d bit errors",
		         coord_errs, dir_errs, bits_errs);
		if (coord_errs + dir_errs + bits_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#1;
		repeat (total_frames + 64) @(posedge Reset);
		$display("timeout: the run did not finish within %0d frames", total_frames + 64);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== tank_game.f ====
+incdir+rtl
rtl/tank_game_pkg.sv
rtl/wall_overlap.sv
rtl/tank_mover.sv
rtl/bullet_step.sv
rtl/bullet_bank.sv
rtl/tank_game_top.sv
testbench/tank_game_tb.sv

// ==== Bender.yml ====
package:
  name: tank_game

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tank_game_pkg.sv
      - rtl/wall_overlap.sv
      - rtl/tank_mover.sv
      - rtl/bullet_step.sv
      - rtl/bullet_bank.sv
      - rtl/tank_game_top.sv
      - target: test
        files:
          - testbench/tank_game_tb.sv
